// File: include/rx_frontend_params.svh
`ifndef RX_FRONTEND_PARAMS_SVH
`define RX_FRONTEND_PARAMS_SVH

// Base of the front-end block on the settings bus.
`define RX_SET_BASE 0

// Register offsets from the base.
`define RX_ADDR_SWAP  0
`define RX_ADDR_MAG   1
`define RX_ADDR_PHASE 2
`define RX_ADDR_DC_I  3
`define RX_ADDR_DC_Q  4

// Sample and coefficient widths.
`define RX_ADC_W  16
`define RX_IQ_W   24
`define RX_COEF_W 18

// Loop gain of the DC tracker as a right shift.
// Also the number of fraction bits in the accumulator.
`define RX_DC_SHIFT 12

`endif

// File: rtl/rx_settings_pkg.sv
`default_nettype none

`include "rx_frontend_params.svh"

package rx_settings_pkg;

   typedef logic [7:0]  set_addr_t;
   typedef logic [31:0] set_data_t;

   // DC offset load request for one channel.
   typedef struct packed
   {
      logic                       load;   // One cycle strobe.
      logic                       fixed;  // 1 holds the value, 0 tracks.
      logic signed [`RX_IQ_W-1:0] value;
   } dc_cmd_t;

   // Static front-end configuration.
   typedef struct packed
   {
      logic                         swap;
      logic signed [`RX_COEF_W-1:0] mag;
      logic signed [`RX_COEF_W-1:0] phase;
   } fe_cfg_t;

endpackage

`default_nettype wire

// File: rtl/rx_sample_pkg.sv
`default_nettype none

`include "rx_frontend_params.svh"

package rx_sample_pkg;

   typedef logic signed [`RX_ADC_W-1:0]  adc_word_t;
   typedef logic signed [`RX_IQ_W-1:0]   iq_word_t;
   typedef logic signed [`RX_COEF_W-1:0] coef_t;

   // One I/Q sample moving down the pipeline.
   // Valid marks a new item; the rest is held between items.
   typedef struct packed
   {
      logic     valid;
      iq_word_t i;
      iq_word_t q;
      logic     ovf_i;
      logic     ovf_q;
   } iq_pair_t;

endpackage

`default_nettype wire

// File: rtl/rx_settings_regs.sv
`default_nettype none

`include "rx_frontend_params.svh"

module rx_settings_regs
(
   input  wire logic                       clk,
   input  wire logic                       rst_n_i,
   input  wire logic                       set_stb_i,
   input  wire rx_settings_pkg::set_addr_t set_addr_i,
   input  wire rx_settings_pkg::set_data_t set_data_i,
   output rx_settings_pkg::fe_cfg_t        cfg_o,
   output rx_settings_pkg::dc_cmd_t        dc_i_cmd_o,
   output rx_settings_pkg::dc_cmd_t        dc_q_cmd_o
);

   import rx_settings_pkg::*;

   localparam set_addr_t ADDR_SWAP  = set_addr_t'(`RX_SET_BASE + `RX_ADDR_SWAP);
   localparam set_addr_t ADDR_MAG   = set_addr_t'(`RX_SET_BASE + `RX_ADDR_MAG);
   localparam set_addr_t ADDR_PHASE = set_addr_t'(`RX_SET_BASE + `RX_ADDR_PHASE);
   localparam set_addr_t ADDR_DC_I  = set_addr_t'(`RX_SET_BASE + `RX_ADDR_DC_I);
   localparam set_addr_t ADDR_DC_Q  = set_addr_t'(`RX_SET_BASE + `RX_ADDR_DC_Q);

   // Bit 31 selects the mode, the low 24 bits carry the offset.
   function automatic dc_cmd_t dc_load(input set_data_t data);
      dc_cmd_t cmd;
      cmd.load  = 1'b1;
      cmd.fixed = data[31];
      cmd.value = data[`RX_IQ_W-1:0];
      return cmd;
   endfunction

   always_ff @(posedge clk)
   begin
      if (!rst_n_i)
      begin
         cfg_o      <= '0;
         dc_i_cmd_o <= '0;
         dc_q_cmd_o <= '0;
      end
      else
      begin
         dc_i_cmd_o.load <= 1'b0;  // Strobe lasts one cycle.
         dc_q_cmd_o.load <= 1'b0;
         if (set_stb_i)
         begin
            case (set_addr_i)
               ADDR_SWAP:  cfg_o.swap  <= set_data_i[0];
               ADDR_MAG:   cfg_o.mag   <= set_data_i[`RX_COEF_W-1:0];
               ADDR_PHASE: cfg_o.phase <= set_data_i[`RX_COEF_W-1:0];
               ADDR_DC_I:  dc_i_cmd_o  <= dc_load(set_data_i);
               ADDR_DC_Q:  dc_q_cmd_o  <= dc_load(set_data_i);
               default:
               begin
               end
            endcase
         end
      end
   end

endmodule

`default_nettype wire

// File: rtl/rx_adc_capture.sv
`default_nettype none

`include "rx_frontend_params.svh"

module rx_adc_capture
(
   input  wire logic                     clk,
   input  wire logic                     rst_n_i,
   input  wire rx_sample_pkg::adc_word_t adc_a_i,
   input  wire rx_sample_pkg::adc_word_t adc_b_i,
   input  wire logic                     adc_ovf_a_i,
   input  wire logic                     adc_ovf_b_i,
   input  wire logic                     adc_valid_i,
   input  wire logic                     swap_i,
   output rx_sample_pkg::iq_pair_t       raw_o
);

   import rx_sample_pkg::*;

   // ADC word goes to the top bits, zeros fill below.
   function automatic iq_word_t widen(input adc_word_t s);
      return {s, {(`RX_IQ_W - `RX_ADC_W){1'b0}}};
   endfunction

   always_ff @(posedge clk)
   begin
      if (!rst_n_i)
         raw_o.valid <= 1'b0;
      else
         raw_o.valid <= adc_valid_i;

      if (adc_valid_i)
      begin
         if (swap_i)
         begin
            raw_o.i     <= widen(adc_b_i);
            raw_o.q     <= widen(adc_a_i);
            raw_o.ovf_i <= adc_ovf_b_i;
            raw_o.ovf_q <= adc_ovf_a_i;
         end
         else
         begin
            raw_o.i     <= widen(adc_a_i);
            raw_o.q     <= widen(adc_b_i);
            raw_o.ovf_i <= adc_ovf_a_i;
            raw_o.ovf_q <= adc_ovf_b_i;
         end
      end
   end

endmodule

`default_nettype wire

// File: rtl/rx_dcoffset.sv
`default_nettype none

`include "rx_frontend_params.svh"

module rx_dcoffset
(
   input  wire logic                     clk,
   input  wire logic                     rst_n_i,
   input  wire rx_settings_pkg::dc_cmd_t cmd_i,
   input  wire logic                     in_valid_i,
   input  wire rx_sample_pkg::iq_word_t  in_i,
   output logic                          out_valid_o,
   output rx_sample_pkg::iq_word_t       out_o
);

   import rx_sample_pkg::*;

   localparam int ACC_W = `RX_IQ_W + `RX_DC_SHIFT;

   localparam iq_word_t MAX_VAL = {1'b0, {(`RX_IQ_W-1){1'b1}}};
   localparam iq_word_t MIN_VAL = {1'b1, {(`RX_IQ_W-1){1'b0}}};

   logic signed [ACC_W-1:0]   acc;  // Offset with RX_DC_SHIFT fraction bits.
   logic                      fixed_q;
   iq_word_t                  ofs;
   logic signed [`RX_IQ_W:0]  diff;
   iq_word_t                  sat;
   logic signed [ACC_W-1:0]   step;

   assign ofs  = acc[ACC_W-1 -: `RX_IQ_W];
   assign diff = in_i - ofs;

   // Clip when the sign bit and the extra bit disagree.
   always_comb
   begin
      if (diff[`RX_IQ_W] != diff[`RX_IQ_W-1])
         sat = diff[`RX_IQ_W] ? MIN_VAL : MAX_VAL;
      else
         sat = diff[`RX_IQ_W-1:0];
   end

   // Output aligned to the accumulator LSB, i.e. shifted right by
   // RX_DC_SHIFT in offset units.
   assign step = sat;

   always_ff @(posedge clk)
   begin
      if (!rst_n_i)
      begin
         acc         <= '0;
         fixed_q     <= 1'b0;  // Tracking after reset.
         out_valid_o <= 1'b0;
      end
      else
      begin
         out_valid_o <= in_valid_i;
         if (cmd_i.load)
         begin
            acc     <= {cmd_i.value, {`RX_DC_SHIFT{1'b0}}};
            fixed_q <= cmd_i.fixed;
         end
         else if (in_valid_i && !fixed_q)
            acc <= acc + step;
      end
   end

   always_ff @(posedge clk)
   begin
      if (in_valid_i)
         out_o <= sat;
   end

endmodule

`default_nettype wire

// File: rtl/rx_iq_correct.sv
`default_nettype none

`include "rx_frontend_params.svh"

module rx_iq_correct
#(
   parameter int IQCOMP_EN = 1
)
(
   input  wire logic                     clk,
   input  wire logic                     rst_n_i,
   input  wire rx_settings_pkg::fe_cfg_t cfg_i,
   input  wire rx_sample_pkg::iq_pair_t  in_i,
   output rx_sample_pkg::iq_pair_t       out_o
);

   import rx_sample_pkg::*;

   localparam int PROD_W = 2 * `RX_COEF_W;

   localparam iq_word_t MAX_VAL = {1'b0, {(`RX_IQ_W-1){1'b1}}};
   localparam iq_word_t MIN_VAL = {1'b1, {(`RX_IQ_W-1){1'b0}}};

   logic signed [PROD_W-1:0] prod_mag_d;
   logic signed [PROD_W-1:0] prod_phase_d;
   logic signed [PROD_W-1:0] prod_mag_q;
   logic signed [PROD_W-1:0] prod_phase_q;
   iq_pair_t                 s1;

   function automatic iq_word_t add_clip(input iq_word_t a, input iq_word_t b);
      logic signed [`RX_IQ_W:0] sum;
      sum = a + b;
      if (sum[`RX_IQ_W] != sum[`RX_IQ_W-1])
         return sum[`RX_IQ_W] ? MIN_VAL : MAX_VAL;
      return sum[`RX_IQ_W-1:0];
   endfunction

   generate
      if (IQCOMP_EN != 0)
      begin : g_mult
         coef_t i_hi;

         assign i_hi         = in_i.i[`RX_IQ_W-1 -: `RX_COEF_W];  // Top 18 bits of I.
         assign prod_mag_d   = i_hi * cfg_i.mag;
         assign prod_phase_d = i_hi * cfg_i.phase;
      end
      else
      begin : g_bypass
         assign prod_mag_d   = '0;
         assign prod_phase_d = '0;
      end
   endgenerate

   // Valid bits of both stages.
   always_ff @(posedge clk)
   begin
      if (!rst_n_i)
      begin
         s1.valid    <= 1'b0;
         out_o.valid <= 1'b0;
      end
      else
      begin
         s1.valid    <= in_i.valid;
         out_o.valid <= s1.valid;
      end
   end

   // Stage 1 holds the sample and both products.
   always_ff @(posedge clk)
   begin
      if (in_i.valid)
      begin
         s1.i         <= in_i.i;
         s1.q         <= in_i.q;
         s1.ovf_i     <= in_i.ovf_i;
         s1.ovf_q     <= in_i.ovf_q;
         prod_mag_q   <= prod_mag_d;
         prod_phase_q <= prod_phase_d;
      end
   end

   // Stage 2 adds and clips.
   always_ff @(posedge clk)
   begin
      if (s1.valid)
      begin
         out_o.i     <= add_clip(s1.i, prod_mag_q[PROD_W-1 -: `RX_IQ_W]);
         out_o.q     <= add_clip(s1.q, prod_phase_q[PROD_W-1 -: `RX_IQ_W]);
         out_o.ovf_i <= s1.ovf_i;
         out_o.ovf_q <= s1.ovf_q;
      end
   end

endmodule

`default_nettype wire

// File: rtl/rx_frontend.sv
`default_nettype none

module rx_frontend
#(
   parameter int IQCOMP_EN = 1
)
(
   input  wire logic                       clk,
   input  wire logic                       rst_n_i,
   input  wire logic                       set_stb_i,
   input  wire rx_settings_pkg::set_addr_t set_addr_i,
   input  wire rx_settings_pkg::set_data_t set_data_i,
   input  wire rx_sample_pkg::adc_word_t   adc_a_i,
   input  wire logic                       adc_ovf_a_i,
   input  wire rx_sample_pkg::adc_word_t   adc_b_i,
   input  wire logic                       adc_ovf_b_i,
   input  wire logic                       adc_valid_i,
   output logic                            out_valid_o,
   output rx_sample_pkg::iq_word_t         i_o,
   output rx_sample_pkg::iq_word_t         q_o,
   output logic                            ovf_i_o,
   output logic                            ovf_q_o
);

   import rx_settings_pkg::*;
   import rx_sample_pkg::*;

   fe_cfg_t  cfg;
   dc_cmd_t  dc_i_cmd;
   dc_cmd_t  dc_q_cmd;
   iq_pair_t raw;
   iq_pair_t dc_pair;
   iq_pair_t corr;
   logic     dc_valid_i;
   logic     dc_valid_q;
   logic     ovf_i_q;
   logic     ovf_q_q;

   rx_settings_regs u_settings (
      .clk, .rst_n_i, .set_stb_i, .set_addr_i, .set_data_i,
      .cfg_o(cfg), .dc_i_cmd_o(dc_i_cmd), .dc_q_cmd_o(dc_q_cmd));

   rx_adc_capture u_capture (
      .clk, .rst_n_i, .adc_a_i, .adc_b_i, .adc_ovf_a_i, .adc_ovf_b_i,
      .adc_valid_i, .swap_i(cfg.swap), .raw_o(raw));

   rx_dcoffset u_dc_i (
      .clk, .rst_n_i, .cmd_i(dc_i_cmd), .in_valid_i(raw.valid), .in_i(raw.i),
      .out_valid_o(dc_valid_i), .out_o(dc_pair.i));

   rx_dcoffset u_dc_q (
      .clk, .rst_n_i, .cmd_i(dc_q_cmd), .in_valid_i(raw.valid), .in_i(raw.q),
      .out_valid_o(dc_valid_q), .out_o(dc_pair.q));

   // Overflow flags ride alongside the DC stage.
   always_ff @(posedge clk)
   begin
      if (raw.valid)
      begin
         ovf_i_q <= raw.ovf_i;
         ovf_q_q <= raw.ovf_q;
      end
   end

   assign dc_pair.valid = dc_valid_i & dc_valid_q;  // Both channels step together.
   assign dc_pair.ovf_i = ovf_i_q;
   assign dc_pair.ovf_q = ovf_q_q;

   rx_iq_correct #(.IQCOMP_EN(IQCOMP_EN)) u_iq_correct (
      .clk, .rst_n_i, .cfg_i(cfg), .in_i(dc_pair), .out_o(corr));

   assign out_valid_o = corr.valid;
   assign i_o         = corr.i;
   assign q_o         = corr.q;
   assign ovf_i_o     = corr.ovf_i;
   assign ovf_q_o     = corr.ovf_q;

endmodule

`default_nettype wire

// File: verification/rx_clock_gen.sv
`default_nettype none

module rx_clock_gen
#(
   parameter int HALF_PERIOD  = 4,
   parameter int RESET_CYCLES = 8
)
(
   output logic clk_o,
   output logic rst_n_o
);

   timeunit 1ns;
   timeprecision 100ps;

   initial
   begin
      clk_o = 1'b0;
      forever #HALF_PERIOD clk_o = ~clk_o;
   end

   // Reset drops on a rising edge, like every other stimulus.
   initial
   begin
      rst_n_o = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk_o);
      rst_n_o <= 1'b1;
   end

endmodule

`default_nettype wire

// File: verification/rx_frontend_tb.sv
`default_nettype none

`include "rx_frontend_params.svh"

module rx_frontend_tb;

   timeunit 1ns;
   timeprecision 100ps;

   import rx_settings_pkg::*;
   import rx_sample_pkg::*;

   localparam int     LATENCY   = 4;
   localparam int     ADC_PAD   = `RX_IQ_W - `RX_ADC_W;
   localparam int     I_DROP    = `RX_IQ_W - `RX_COEF_W;      // I bits below the multiplier input.
   localparam int     PROD_DROP = 2 * `RX_COEF_W - `RX_IQ_W;  // Product bits below the sum.
   localparam longint IQ_MAX    = (longint'(1) <<< (`RX_IQ_W - 1)) - 1;
   localparam longint IQ_MIN    = -(longint'(1) <<< (`RX_IQ_W - 1));
   localparam int     TIMEOUT   = 200;

   typedef struct packed
   {
      iq_word_t    i;
      iq_word_t    q;
      logic        ovf_i;
      logic        ovf_q;
      logic [31:0] cyc;  // Edge at which the monitor must see it.
   } expect_t;

   logic        clk;
   logic        rst_n;
   logic        set_stb_i;
   set_addr_t   set_addr_i;
   set_data_t   set_data_i;
   adc_word_t   adc_a_i;
   adc_word_t   adc_b_i;
   logic        adc_ovf_a_i;
   logic        adc_ovf_b_i;
   logic        adc_valid_i;
   logic        out_valid_o;
   iq_word_t    i_o;
   iq_word_t    q_o;
   logic        ovf_i_o;
   logic        ovf_q_o;

   expect_t     exp_q[$];
   string       test_name = "reset";
   int unsigned cycle = 0;
   iq_word_t    last_i;
   iq_word_t    last_q;
   logic [31:0] lcg_state = 32'd43;

   // Reference state, as written over the settings bus.
   logic        m_swap = 1'b0;
   longint      m_mag = 0;
   longint      m_phase = 0;
   logic        dc_fixed [2] = '{1'b0, 1'b0};
   longint      dc_acc [2] = '{0, 0};  // Offset with RX_DC_SHIFT fraction bits.

   rx_clock_gen u_clock_gen (.clk_o(clk), .rst_n_o(rst_n));

   rx_frontend u_rx_frontend (
      .clk         (clk),
      .rst_n_i     (rst_n),
      .set_stb_i   (set_stb_i),
      .set_addr_i  (set_addr_i),
      .set_data_i  (set_data_i),
      .adc_a_i     (adc_a_i),
      .adc_ovf_a_i (adc_ovf_a_i),
      .adc_b_i     (adc_b_i),
      .adc_ovf_b_i (adc_ovf_b_i),
      .adc_valid_i (adc_valid_i),
      .out_valid_o (out_valid_o),
      .i_o         (i_o),
      .q_o         (q_o),
      .ovf_i_o     (ovf_i_o),
      .ovf_q_o     (ovf_q_o));

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic longint clip_to_iq(input longint v);
      if (v > IQ_MAX)
         return IQ_MAX;
      if (v < IQ_MIN)
         return IQ_MIN;
      return v;
   endfunction

   // One DC channel: subtract the offset, then let the loop follow the output.
   function automatic longint remove_dc(input int ch, input longint x);
      longint y;
      y = clip_to_iq(x - (dc_acc[ch] >>> `RX_DC_SHIFT));
      if (!dc_fixed[ch])
         dc_acc[ch] += y;
      return y;
   endfunction

   task automatic report_failure(input string msg);
      $display("%s", msg);
      $display("Testbench failed");
      $fatal(1, "simulation stopped at the first failing check");
   endtask

   task automatic report_mismatch(input string what, input longint exp, input longint act);
      report_failure($sformatf("Error: %s: %s expected %0d actual %0d",
                               test_name, what, exp, act));
   endtask

   task automatic predict_output(input adc_word_t a, input adc_word_t b,
                                 input logic ova, input logic ovb);
      expect_t e;
      longint  dc_i;
      longint  dc_q;
      longint  prod_m;
      longint  prod_p;
      dc_i   = remove_dc(0, longint'(m_swap ? b : a) <<< ADC_PAD);
      dc_q   = remove_dc(1, longint'(m_swap ? a : b) <<< ADC_PAD);
      prod_m = (dc_i >>> I_DROP) * m_mag;
      prod_p = (dc_i >>> I_DROP) * m_phase;
      e.i     = iq_word_t'(clip_to_iq(dc_i + (prod_m >>> PROD_DROP)));
      e.q     = iq_word_t'(clip_to_iq(dc_q + (prod_p >>> PROD_DROP)));
      e.ovf_i = m_swap ? ovb : ova;
      e.ovf_q = m_swap ? ova : ovb;
      e.cyc   = cycle + 1 + LATENCY;  // The DUT samples it one edge after the drive.
      exp_q.push_back(e);
   endtask

   task automatic check_output();
      expect_t e;
      e = exp_q.pop_front();
      last_i = i_o;
      last_q = q_o;
      assert (i_o == e.i) else report_mismatch("I", signed'(e.i), i_o);
      assert (q_o == e.q) else report_mismatch("Q", signed'(e.q), q_o);
      assert (ovf_i_o == e.ovf_i) else report_mismatch("overflow I", e.ovf_i, ovf_i_o);
      assert (ovf_q_o == e.ovf_q) else report_mismatch("overflow Q", e.ovf_q, ovf_q_o);
      assert (cycle == e.cyc) else report_mismatch("output cycle", e.cyc, cycle);
   endtask

   always @(posedge clk)
      cycle <= cycle + 1;

   always @(posedge clk)
   begin
      if (rst_n && out_valid_o)
      begin
         assert (exp_q.size() != 0) check_output();
         else report_failure($sformatf("%s: output valid with no sample pending", test_name));
      end
   end

   task automatic wait_for_reset();
      int n;
      n = 0;
      while (rst_n !== 1'b1)
      begin
         @(negedge clk);
         n++;
         assert (n < TIMEOUT) else report_failure("reset was never released");
      end
   endtask

   // Stops the stream and waits until every sample has come out.
   task automatic wait_for_drain();
      int n;
      n = 0;
      @(posedge clk);
      adc_valid_i <= 1'b0;
      while (exp_q.size() != 0)
      begin
         @(negedge clk);
         n++;
         assert (n < TIMEOUT)
         else report_failure($sformatf("%s: timeout waiting for outputs", test_name));
      end
   endtask

   task automatic write_reg(input int offset, input set_data_t data);
      iq_word_t v;
      wait_for_drain();
      @(posedge clk);
      set_stb_i  <= 1'b1;
      set_addr_i <= set_addr_t'(`RX_SET_BASE + offset);
      set_data_i <= data;
      @(posedge clk);
      set_stb_i  <= 1'b0;
      v = data[`RX_IQ_W-1:0];
      case (offset)
         `RX_ADDR_SWAP:  m_swap  = data[0];
         `RX_ADDR_MAG:   m_mag   = coef_t'(data[`RX_COEF_W-1:0]);
         `RX_ADDR_PHASE: m_phase = coef_t'(data[`RX_COEF_W-1:0]);
         `RX_ADDR_DC_I:
         begin
            dc_fixed[0] = data[31];
            dc_acc[0]   = longint'(v) <<< `RX_DC_SHIFT;
         end
         `RX_ADDR_DC_Q:
         begin
            dc_fixed[1] = data[31];
            dc_acc[1]   = longint'(v) <<< `RX_DC_SHIFT;
         end
         default:
         begin
         end
      endcase
   endtask

   task automatic send_sample(input adc_word_t a, input adc_word_t b,
                              input logic ova, input logic ovb);
      @(posedge clk);
      adc_a_i     <= a;
      adc_b_i     <= b;
      adc_ovf_a_i <= ova;
      adc_ovf_b_i <= ovb;
      adc_valid_i <= 1'b1;
      predict_output(a, b, ova, ovb);
   endtask

   task automatic send_random();
      logic [31:0] r;
      logic [31:0] s;
      r = lcg_next();
      s = lcg_next();
      send_sample(adc_word_t'(r[31:16]), adc_word_t'(s[31:16]), r[14], s[13]);
   endtask

   // Garbage on the data lines while valid is low.
   task automatic idle_cycles(input int n);
      repeat (n)
      begin
         @(posedge clk);
         adc_valid_i <= 1'b0;
         adc_a_i     <= adc_word_t'(lcg_next() >> 16);
         adc_b_i     <= adc_word_t'(lcg_next() >> 16);
      end
   endtask

   task automatic defaults_and_swap();
      test_name = "defaults_and_swap";
      write_reg(`RX_ADDR_DC_I, 32'h8000_0000);
      write_reg(`RX_ADDR_DC_Q, 32'h8000_0000);
      for (int s = 0; s < 2; s++)
      begin
         write_reg(`RX_ADDR_SWAP, s);
         send_sample(16'sh7FFF, 16'sh8000, 1'b1, 1'b0);
         send_sample(16'sh8000, 16'sh7FFF, 1'b0, 1'b1);
         repeat (16) send_random();
      end
      write_reg(`RX_ADDR_SWAP, 0);
   endtask

   task automatic fixed_offset_clip();
      logic [23:0] ofs_list [6];
      ofs_list  = '{24'h000000, 24'h000100, 24'hFFF000, 24'h001234, 24'h7FFFFF, 24'h800000};
      test_name = "fixed_offset_clip";
      foreach (ofs_list[n])
      begin
         write_reg(`RX_ADDR_DC_I, {8'h80, ofs_list[n]});
         write_reg(`RX_ADDR_DC_Q, {8'h80, ofs_list[5 - n]});
         send_sample(16'sh7FFF, 16'sh8000, 1'b0, 1'b0);
         send_sample(16'sh8000, 16'sh7FFF, 1'b0, 1'b0);
         send_sample(16'sh0000, 16'sh0001, 1'b1, 1'b1);
         repeat (8) send_random();
      end
   endtask

   task automatic iq_correction();
      test_name = "iq_correction";
      write_reg(`RX_ADDR_DC_I, 32'h8000_0000);
      write_reg(`RX_ADDR_DC_Q, 32'h8000_0000);
      for (int n = 0; n < 5; n++)
      begin
         if (n == 0)
         begin
            write_reg(`RX_ADDR_MAG, 32'h0001_FFFF);  // Largest gain, smallest phase.
            write_reg(`RX_ADDR_PHASE, 32'h0002_0000);
         end
         else
         begin
            write_reg(`RX_ADDR_MAG, lcg_next());
            write_reg(`RX_ADDR_PHASE, lcg_next());
         end
         send_sample(16'sh7FFF, 16'sh7FFF, 1'b0, 1'b0);
         send_sample(16'sh8000, 16'sh7FFF, 1'b0, 1'b0);
         send_sample(16'sh8000, 16'sh8000, 1'b0, 1'b0);
         repeat (32) send_random();
      end
   endtask

   task automatic dc_tracking();
      longint res_i;
      longint res_q;
      test_name = "dc_tracking";
      write_reg(`RX_ADDR_MAG, 0);
      write_reg(`RX_ADDR_PHASE, 0);
      write_reg(`RX_ADDR_DC_I, 32'h0000_0000);
      write_reg(`RX_ADDR_DC_Q, 32'h0000_0000);
      repeat (20000) send_sample(adc_word_t'(-1500), adc_word_t'(1200), 1'b0, 1'b0);
      wait_for_drain();
      res_i = (last_i < 0) ? -longint'(last_i) : longint'(last_i);
      res_q = (last_q < 0) ? -longint'(last_q) : longint'(last_q);
      assert (res_i < (1 << `RX_DC_SHIFT))
      else report_failure($sformatf("Error: %s: residual I expected below %0d actual %0d",
                                    test_name, 1 << `RX_DC_SHIFT, res_i));
      assert (res_q < (1 << `RX_DC_SHIFT))
      else report_failure($sformatf("Error: %s: residual Q expected below %0d actual %0d",
                                    test_name, 1 << `RX_DC_SHIFT, res_q));
      write_reg(`RX_ADDR_DC_I, 32'h8000_0000);
      write_reg(`RX_ADDR_DC_Q, 32'h8000_0000);
      repeat (8) send_sample(adc_word_t'(-1500), adc_word_t'(1200), 1'b0, 1'b0);
      wait_for_drain();
      assert (last_i == -1500 * 256) else report_mismatch("restored I", -1500 * 256, last_i);
      assert (last_q == 1200 * 256) else report_mismatch("restored Q", 1200 * 256, last_q);
   endtask

   task automatic gaps_and_latency();
      test_name = "gaps_and_latency";
      write_reg(`RX_ADDR_MAG, lcg_next());
      write_reg(`RX_ADDR_PHASE, lcg_next());
      write_reg(`RX_ADDR_DC_I, 32'h8000_0000 | (lcg_next() & 32'h000F_FFFF));
      write_reg(`RX_ADDR_DC_Q, 32'h8000_0000 | (lcg_next() & 32'h000F_FFFF));
      repeat (300)
      begin
         idle_cycles((lcg_next() >> 16) % 4);
         send_random();
      end
      wait_for_drain();
   endtask

   initial
   begin
      set_stb_i   = 1'b0;
      set_addr_i  = '0;
      set_data_i  = '0;
      adc_a_i     = '0;
      adc_b_i     = '0;
      adc_ovf_a_i = 1'b0;
      adc_ovf_b_i = 1'b0;
      adc_valid_i = 1'b0;
      wait_for_reset();
      defaults_and_swap();
      fixed_offset_clip();
      iq_correction();
      dc_tracking();
      gaps_and_latency();
      wait_for_drain();
      $display("Testbench passed");
      $finish;
   end

endmodule

`default_nettype wire

// File: files.f
+incdir+include
rtl/rx_settings_pkg.sv
rtl/rx_sample_pkg.sv
rtl/rx_settings_regs.sv
rtl/rx_adc_capture.sv
rtl/rx_dcoffset.sv
rtl/rx_iq_correct.sv
rtl/rx_frontend.sv
verification/rx_clock_gen.sv
verification/rx_frontend_tb.sv

// File: Makefile
TOP := rx_frontend_tb
LOG := sim.log

SOURCES := files.f $(wildcard rtl/*.sv verification/*.sv include/*.svh)

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): $(SOURCES)
	verilator --binary --timing -Wno-fatal --timescale 1ns/1ps \
		-f files.f --top-module $(TOP) -o V$(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Testbench passed" $(LOG)

lint:
	verilator --lint-only --timing -Wall --timescale 1ns/1ps \
		-f files.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)
